// File: common/memconfig_params.svh
// Address map of the bus subsystem and the data memory depth.
// Ranges are half-open: START is inside, END is the first address outside.
// Include wherever an address is decoded.
`ifndef MEMCONFIG_PARAMS_SVH
`define MEMCONFIG_PARAMS_SVH

// Data memory region
`define DATA_STARTADDR 32'h0000_0000
`define DATA_ENDADDR 32'h0000_3000
`define DM_WORDS 3072

// Whole device window
`define DEV_STARTADDR 32'h0000_7F00
`define DEV_ENDADDR 32'h0000_7F2C

// Timers, three registers each
`define TIMER0_STARTADDR 32'h0000_7F00
`define TIMER0_ENDADDR 32'h0000_7F0C
`define TIMER1_STARTADDR 32'h0000_7F10
`define TIMER1_ENDADDR 32'h0000_7F1C

// Single-word I/O registers
`define LED_ADDR 32'h0000_7F20
`define DIGITALTUBE_ADDR 32'h0000_7F24
`define BUTTONSWITCH_ADDR 32'h0000_7F28

`endif

// File: common/bridge_pkg.sv
// Shared types for the memory-mapped bus subsystem.
// Bridges use the region and device enums for address decode.
// The timer uses the mode and register-offset enums.
package bridge_pkg;

    // North bridge target region
    typedef enum logic [1:0] {
        regionDm,
        regionDev,
        regionNone
    } regionT;

    // South bridge target device
    typedef enum logic [2:0] {
        devTimer0,
        devTimer1,
        devLed,
        devTube,
        devSwitch,
        devNone
    } deviceT;

    // Timer mode, ctrl bit 1
    typedef enum logic {
        modeOneShot,
        modeReload
    } timerModeT;

    // Word offset inside a timer, taken from address bits 3:2
    typedef enum logic [1:0] {
        regCtrl   = 2'd0,
        regPreset = 2'd1,
        regCount  = 2'd2
    } timerRegT;

endpackage

// File: common/busIf.sv
// Single-cycle bus links used inside the subsystem.
// memBusIf goes to the data memory and carries byte enables.
// devBusIf goes to the south bridge and to each device, with one strobe
// and an interrupt line back from the device.
`timescale 1ns/1ps

interface memBusIf;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [3:0]  we;
    logic [31:0] rData;

    modport master (output addr, output wData, output we, input rData);
    modport slave (input addr, input wData, input we, output rData);
endinterface

interface devBusIf;
    logic [31:0] addr;
    logic [31:0] wData;
    logic        we;
    logic [31:0] rData;
    logic        intr;

    modport master (output addr, output wData, output we, input rData, input intr);
    modport slave (input addr, input wData, input we, output rData, output intr);
endinterface

// File: design/dataMemory.sv
// Word-organized data RAM on the memBusIf link.
// Writes the enabled bytes on the rising edge, reads combinationally.
// Contents are not initialized.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module dataMemory (
    input logic    clk,
    input logic    rstN,
    memBusIf.slave bus
);

    logic [31:0] mem [0:`DM_WORDS-1];
    logic [11:0] wordIdx;
    logic [3:0]  byteWe;

    assign wordIdx = bus.addr[13:2];

    // No writes land while reset is held
    assign byteWe = rstN ? bus.we : 4'b0000;

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (byteWe[b]) begin
                mem[wordIdx][8*b +: 8] <= bus.wData[8*b +: 8];
            end
        end
    end

    assign bus.rData = mem[wordIdx];

endmodule

// File: timer/timer.sv
// Countdown timer with ctrl, preset and count registers.
// ctrl bit 0 enables, bit 1 selects reload mode, bit 3 unmasks the interrupt.
// Writing preset also loads count; count itself is read-only.
// At zero, one-shot mode stops the timer and reload mode restarts from preset.
`timescale 1ns/1ps

module timer (
    input logic    clk,
    input logic    rstN,
    devBusIf.slave bus
);

    bridge_pkg::timerRegT  regSel;
    bridge_pkg::timerModeT mode;
    logic        enable;
    logic        intMask;
    logic        flag;
    logic [31:0] preset;
    logic [31:0] count;
    logic [31:0] ctrlWord;

    assign regSel   = bridge_pkg::timerRegT'(bus.addr[3:2]);
    assign ctrlWord = {28'h0, intMask, 1'b0, mode, enable};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enable  <= 1'b0;
            mode    <= bridge_pkg::modeOneShot;
            intMask <= 1'b0;
            flag    <= 1'b0;
            preset  <= 32'h0;
            count   <= 32'h0;
        end else if (bus.we && regSel == bridge_pkg::regCtrl) begin
            // Any ctrl write acknowledges the interrupt
            enable  <= bus.wData[0];
            mode    <= bridge_pkg::timerModeT'(bus.wData[1]);
            intMask <= bus.wData[3];
            flag    <= 1'b0;
        end else if (bus.we && regSel == bridge_pkg::regPreset) begin
            preset <= bus.wData;
            count  <= bus.wData;
        end else if (enable) begin
            if (count == 32'h0) begin
                flag <= 1'b1;
                if (mode == bridge_pkg::modeReload) begin
                    count <= preset;
                end else begin
                    enable <= 1'b0;
                end
            end else begin
                count <= count - 32'd1;
            end
        end
    end

    always_comb begin
        case (regSel)
            bridge_pkg::regCtrl:   bus.rData = ctrlWord;
            bridge_pkg::regPreset: bus.rData = preset;
            bridge_pkg::regCount:  bus.rData = count;
            default:               bus.rData = 32'h0;
        endcase
    end

    assign bus.intr = flag & intMask;

endmodule

// File: design/ioPorts.sv
// Board I/O behind the south bridge: LED and digital-tube output registers
// and the button-switch input. The switches are sampled once per cycle and
// a change raises the interrupt until the switch address is written.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module ioPorts (
    input  logic        clk,
    input  logic        rstN,
    devBusIf.slave      bus,
    input  logic [31:0] switches,
    output logic [31:0] led,
    output logic [31:0] tube
);

    logic [31:0] ledReg;
    logic [31:0] tubeReg;
    logic [31:0] swReg;
    logic        swChanged;
    logic        selLed;
    logic        selTube;
    logic        selSwitch;

    assign selLed    = (bus.addr == `LED_ADDR);
    assign selTube   = (bus.addr == `DIGITALTUBE_ADDR);
    assign selSwitch = (bus.addr == `BUTTONSWITCH_ADDR);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ledReg    <= 32'h0;
            tubeReg   <= 32'h0;
            swReg     <= 32'h0;
            swChanged <= 1'b0;
        end else begin
            if (bus.we && selLed) begin
                ledReg <= bus.wData;
            end
            if (bus.we && selTube) begin
                tubeReg <= bus.wData;
            end
            swReg <= switches;
            // A fresh change beats a clear in the same cycle
            if (switches != swReg) begin
                swChanged <= 1'b1;
            end else if (bus.we && selSwitch) begin
                swChanged <= 1'b0;
            end
        end
    end

    assign bus.rData = selLed    ? ledReg  :
                       selTube   ? tubeReg :
                       selSwitch ? swReg   : 32'h0;
    assign bus.intr  = swChanged;

    assign led  = ledReg;
    assign tube = tubeReg;

endmodule

// File: design/northBridge.sv
// Splits processor data-port accesses between the data memory and the
// device window behind the south bridge. Read data returns in the same
// cycle; addresses outside both regions read zero and never write.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module northBridge (
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    input  logic [3:0]  we,
    output logic [31:0] rData,
    memBusIf.master     mem,
    devBusIf.master     sb
);

    bridge_pkg::regionT region;

    // Region decode
    always_comb begin
        if (addr >= `DATA_STARTADDR && addr < `DATA_ENDADDR) begin
            region = bridge_pkg::regionDm;
        end else if (addr >= `DEV_STARTADDR && addr < `DEV_ENDADDR) begin
            region = bridge_pkg::regionDev;
        end else begin
            region = bridge_pkg::regionNone;
        end
    end

    assign mem.addr  = addr;
    assign mem.wData = wData;
    assign mem.we    = (region == bridge_pkg::regionDm) ? we : 4'b0000;

    // Devices only take full-word writes
    assign sb.addr  = addr;
    assign sb.wData = wData;
    assign sb.we    = (region == bridge_pkg::regionDev) ? (&we) : 1'b0;

    always_comb begin
        case (region)
            bridge_pkg::regionDm:  rData = mem.rData;
            bridge_pkg::regionDev: rData = sb.rData;
            default:               rData = 32'h0;
        endcase
    end

endmodule

// File: design/southBridge.sv
// Decodes the device window into the two timers and the I/O port.
// Forwards the write strobe to the selected device only, muxes its read
// data back and packs the device interrupts into the hardware vector.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module southBridge (
    devBusIf.slave  up,
    devBusIf.master tmr0,
    devBusIf.master tmr1,
    devBusIf.master io,
    output logic [5:0] hwInt
);

    bridge_pkg::deviceT dev;
    logic ioSel;

    always_comb begin
        dev = bridge_pkg::devNone;
        if (up.addr >= `TIMER0_STARTADDR && up.addr < `TIMER0_ENDADDR) begin
            dev = bridge_pkg::devTimer0;
        end else if (up.addr >= `TIMER1_STARTADDR && up.addr < `TIMER1_ENDADDR) begin
            dev = bridge_pkg::devTimer1;
        end else if (up.addr == `LED_ADDR) begin
            dev = bridge_pkg::devLed;
        end else if (up.addr == `DIGITALTUBE_ADDR) begin
            dev = bridge_pkg::devTube;
        end else if (up.addr == `BUTTONSWITCH_ADDR) begin
            dev = bridge_pkg::devSwitch;
        end
    end

    // LED, tube and switch all live in ioPorts
    assign ioSel = (dev == bridge_pkg::devLed) || (dev == bridge_pkg::devTube) ||
                   (dev == bridge_pkg::devSwitch);

    assign tmr0.addr  = up.addr;
    assign tmr0.wData = up.wData;
    assign tmr0.we    = up.we && (dev == bridge_pkg::devTimer0);

    assign tmr1.addr  = up.addr;
    assign tmr1.wData = up.wData;
    assign tmr1.we    = up.we && (dev == bridge_pkg::devTimer1);

    assign io.addr  = up.addr;
    assign io.wData = up.wData;
    assign io.we    = up.we && ioSel;

    // Holes in the window read zero
    always_comb begin
        case (dev)
            bridge_pkg::devTimer0: up.rData = tmr0.rData;
            bridge_pkg::devTimer1: up.rData = tmr1.rData;
            bridge_pkg::devLed,
            bridge_pkg::devTube,
            bridge_pkg::devSwitch: up.rData = io.rData;
            default:               up.rData = 32'h0;
        endcase
    end

    // Bridge link carries no interrupt
    assign up.intr = 1'b0;
    assign hwInt   = {3'b000, io.intr, tmr1.intr, tmr0.intr};

endmodule

// File: design/busSystem.sv
// Top level of the bus subsystem. The processor data port and the board
// signals are plain ports; inside, the bridges, data memory, two timers
// and the I/O port are joined by bus interfaces.
`timescale 1ns/1ps

module busSystem (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    input  logic [3:0]  we,
    output logic [31:0] rData,
    output logic [7:2]  hwInt,
    output logic [31:0] led,
    output logic [31:0] tube,
    input  logic [31:0] switches
);

    memBusIf memBus ();
    devBusIf sbBus ();
    devBusIf tmr0Bus ();
    devBusIf tmr1Bus ();
    devBusIf ioBus ();

    northBridge northBridge_inst (
        .addr  (addr),
        .wData (wData),
        .we    (we),
        .rData (rData),
        .mem   (memBus.master),
        .sb    (sbBus.master)
    );

    southBridge southBridge_inst (
        .up    (sbBus.slave),
        .tmr0  (tmr0Bus.master),
        .tmr1  (tmr1Bus.master),
        .io    (ioBus.master),
        .hwInt (hwInt)
    );

    dataMemory dataMemory_inst (
        .clk  (clk),
        .rstN (rstN),
        .bus  (memBus.slave)
    );

    timer timer0 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (tmr0Bus.slave)
    );

    timer timer1 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (tmr1Bus.slave)
    );

    ioPorts ioPorts_inst (
        .clk      (clk),
        .rstN     (rstN),
        .bus      (ioBus.slave),
        .switches (switches),
        .led      (led),
        .tube     (tube)
    );

endmodule

// File: verification/busSystem_sva.sv
// Concurrent checks on the top-level ports of the bus subsystem.
// Bound into busSystem, so it needs no instance in the testbench.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module busSystem_sva (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] addr,
    input logic [31:0] rData,
    input logic [7:2]  hwInt,
    input logic [31:0] led,
    input logic [31:0] tube
);

    logic unmapped;

    // Neither data memory nor device window
    assign unmapped = !(addr >= `DATA_STARTADDR && addr < `DATA_ENDADDR) &&
                      !(addr >= `DEV_STARTADDR && addr < `DEV_ENDADDR);

    upperIntZero: assert property (@(posedge clk) hwInt[7:5] == 3'b000)
        else $error("hwInt bits 7 to 5 are not zero");

    resetOutputsZero: assert property (@(posedge clk)
        !rstN |-> (led == 32'h0 && tube == 32'h0 && hwInt == 6'h0))
        else $error("outputs not zero during reset");

    unmappedReadZero: assert property (@(posedge clk) disable iff (!rstN)
        unmapped |-> rData == 32'h0)
        else $error("unmapped address returned nonzero read data");

endmodule

bind busSystem busSystem_sva busSystem_sva_inst (
    .clk   (clk),
    .rstN  (rstN),
    .addr  (addr),
    .rData (rData),
    .hwInt (hwInt),
    .led   (led),
    .tube  (tube)
);

// File: verification/busSystem_tb.sv
// Table-driven testbench for the bus subsystem.
// Builds a list of bus operations with expected values taken from a
// reference model of the memory map, then applies it on the processor port.
`timescale 1ns/1ps
`include "memconfig_params.svh"

module busSystem_tb;

    typedef enum logic [1:0] {
        opWrite,
        opRead,
        opWaitInt,
        opSetSwitch
    } opT;

    typedef struct packed {
        opT          op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] exp;
    } entryT;

    localparam int WAIT_LIMIT = 200;
    localparam int MEM_WORDS_USED = 8;

    logic        clk;
    logic        rstN;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [3:0]  we;
    logic [31:0] rData;
    logic [7:2]  hwInt;
    logic [31:0] led;
    logic [31:0] tube;
    logic [31:0] switches;

    entryT       stimTable[$];
    logic [7:0]  refMem [logic [31:0]];
    logic [31:0] lfsrState;

    busSystem busSystem_inst (
        .clk      (clk),
        .rstN     (rstN),
        .addr     (addr),
        .wData    (wData),
        .we       (we),
        .rData    (rData),
        .hwInt    (hwInt),
        .led      (led),
        .tube     (tube),
        .switches (switches)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsrState = galoisStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] refRead(input logic [31:0] a);
        return {refMem[a + 32'd3], refMem[a + 32'd2], refMem[a + 32'd1], refMem[a]};
    endfunction

    task automatic addEntry(input opT op, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] be, input logic [31:0] exp);
        entryT e;
        e.op   = op;
        e.addr = a;
        e.data = d;
        e.be   = be;
        e.exp  = exp;
        stimTable.push_back(e);
    endtask

    task automatic writeMem(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                refMem[a + 32'(b)] = d[8*b +: 8];
            end
        end
        addEntry(opWrite, a, d, be, 32'h0);
    endtask

    task automatic buildTable();
        logic [31:0] data;
        logic [31:0] beBits;
        // Full words first, then mixed byte enables over the same words
        for (int i = 0; i < MEM_WORDS_USED; i++) begin
            data = randomBits(32);
            writeMem(i * 32'h5F4, data, 4'hF);
        end
        for (int i = 0; i < MEM_WORDS_USED; i++) begin
            data = randomBits(32);
            beBits = randomBits(4);
            writeMem(i * 32'h5F4, data, beBits[3:0]);
        end
        for (int i = 0; i < MEM_WORDS_USED; i++) begin
            addEntry(opRead, i * 32'h5F4, 32'h0, 4'h0, refRead(i * 32'h5F4));
        end
        addEntry(opWrite, `LED_ADDR, 32'h0000_A5C3, 4'hF, 32'h0);
        addEntry(opRead, `LED_ADDR, 32'h0, 4'h0, 32'h0000_A5C3);
        addEntry(opWrite, `DIGITALTUBE_ADDR, 32'h1234_5678, 4'hF, 32'h0);
        addEntry(opRead, `DIGITALTUBE_ADDR, 32'h0, 4'h0, 32'h1234_5678);
        addEntry(opWrite, `LED_ADDR, 32'hFFFF_FFFF, 4'b0011, 32'h0);
        addEntry(opRead, `LED_ADDR, 32'h0, 4'h0, 32'h0000_A5C3);
        // Window hole, gap above data memory, end of window
        addEntry(opRead, 32'h0000_7F0C, 32'h0, 4'h0, 32'h0);
        addEntry(opRead, 32'h0000_4000, 32'h0, 4'h0, 32'h0);
        addEntry(opRead, `DEV_ENDADDR, 32'h0, 4'h0, 32'h0);
        addEntry(opWrite, 32'h0000_7F0C, 32'hFFFF_FFFF, 4'hF, 32'h0);
        // 0x4000 aliases word 0 in the low address bits
        addEntry(opWrite, 32'h0000_4000, 32'hDEAD_BEEF, 4'hF, 32'h0);
        addEntry(opRead, 32'h0, 32'h0, 4'h0, refRead(32'h0));
        addEntry(opRead, `LED_ADDR, 32'h0, 4'h0, 32'h0000_A5C3);
        addEntry(opRead, `TIMER0_STARTADDR, 32'h0, 4'h0, 32'h0);
        // Timer0 one-shot with mask
        addEntry(opWrite, `TIMER0_STARTADDR + 32'h4, 32'd20, 4'hF, 32'h0);
        addEntry(opWrite, `TIMER0_STARTADDR, 32'h9, 4'hF, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd2, 4'h0, 32'h1);
        addEntry(opRead, `TIMER0_STARTADDR + 32'h8, 32'h0, 4'h0, 32'h0);
        addEntry(opRead, `TIMER0_STARTADDR, 32'h0, 4'h0, 32'h8);
        addEntry(opWrite, `TIMER0_STARTADDR, 32'h8, 4'hF, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd2, 4'h0, 32'h0);
        // Timer1 reload fires twice
        addEntry(opWrite, `TIMER1_STARTADDR + 32'h4, 32'd10, 4'hF, 32'h0);
        addEntry(opWrite, `TIMER1_STARTADDR, 32'hB, 4'hF, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd3, 4'h0, 32'h1);
        addEntry(opWrite, `TIMER1_STARTADDR, 32'hB, 4'hF, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd3, 4'h0, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd3, 4'h0, 32'h1);
        addEntry(opRead, `TIMER1_STARTADDR, 32'h0, 4'h0, 32'hB);
        addEntry(opRead, `TIMER1_STARTADDR + 32'h4, 32'h0, 4'h0, 32'd10);
        addEntry(opWrite, `TIMER1_STARTADDR, 32'h0, 4'hF, 32'h0);
        // Switch change interrupt and its clear
        addEntry(opSetSwitch, 32'h0, 32'h0000_00F0, 4'h0, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd4, 4'h0, 32'h1);
        addEntry(opRead, `BUTTONSWITCH_ADDR, 32'h0, 4'h0, 32'h0000_00F0);
        addEntry(opWrite, `BUTTONSWITCH_ADDR, 32'h0, 4'hF, 32'h0);
        addEntry(opWaitInt, 32'h0, 32'd4, 4'h0, 32'h0);
    endtask

    task automatic applyEntry(input entryT e);
        int          waited;
        logic [2:0]  bitSel;
        logic [31:0] portVal;
        @(posedge clk);
        #5;
        addr  = e.addr;
        wData = e.data;
        we    = (e.op == opWrite) ? e.be : 4'h0;
        bitSel = e.data[2:0];
        case (e.op)
            opRead: begin
                @(negedge clk);
                assert (rData === e.exp) else begin
                    $display("CHECK FAILED at %0t: read of %h gave %h, expected %h",
                             $time, e.addr, rData, e.exp);
                    $display("sim failed");
                    $fatal(1, "read mismatch");
                end
                if (e.addr == `LED_ADDR || e.addr == `DIGITALTUBE_ADDR) begin
                    portVal = (e.addr == `LED_ADDR) ? led : tube;
                    assert (portVal === e.exp) else begin
                        $display("CHECK FAILED at %0t: output port for %h is %h, expected %h",
                                 $time, e.addr, portVal, e.exp);
                        $display("sim failed");
                        $fatal(1, "output port mismatch");
                    end
                end
            end
            opSetSwitch: begin
                switches = e.data;
            end
            opWaitInt: begin
                waited = 0;
                @(negedge clk);
                while (hwInt[bitSel] !== e.exp[0]) begin
                    if (waited >= WAIT_LIMIT) begin
                        $display("Timed out after %0d cycles waiting for hwInt bit %0d to be %0b",
                                 waited, bitSel, e.exp[0]);
                        $display("sim failed");
                        $fatal(1, "interrupt wait timeout");
                    end
                    waited++;
                    @(negedge clk);
                end
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        addr      = 32'h0;
        wData     = 32'h0;
        we        = 4'h0;
        switches  = 32'h0;
        lfsrState = 32'hd80a0b34;
        buildTable();
        repeat (16) @(posedge clk);
        #5;
        rstN = 1'b1;
        foreach (stimTable[i]) begin
            applyEntry(stimTable[i]);
        end
        @(posedge clk);
        #5;
        we = 4'h0;
        $display("sim passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+common
common/bridge_pkg.sv
common/busIf.sv
design/dataMemory.sv
timer/timer.sv
design/ioPorts.sv
design/northBridge.sv
design/southBridge.sv
design/busSystem.sv
verification/busSystem_sva.sv
verification/busSystem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = busSystem_tb
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJDIR)
